/* hw/bit_packer.sv */
`timescale 1ns/1ns

module bit_packer import huff_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         bit_valid,
    input  logic         bit_data,
    output logic         bit_ready,
    input  logic         flush,
    output logic         flush_done,
    output byte_stream_t byte_out,
    input  logic         byte_ready
);

    logic [byte_w-1:0] sr;           // Newest bit in the LSB
    logic [fill_w-1:0] fill;
    logic              out_valid;
    logic [byte_w-1:0] out_data;
    logic              flush_pend;   // Flush seen while a byte was still held
    logic              flush_req;
    logic              bit_fire;
    logic [byte_w-1:0] shift_next;
    logic [byte_w-1:0] pad_byte;
    logic              load_full;
    logic              load_pad;
    logic              done_now;

    assign bit_ready  = ~out_valid;   // Stalled while a byte waits
    assign bit_fire   = bit_valid & bit_ready;
    assign flush_req  = flush | flush_pend;
    assign shift_next = {sr[byte_w-2:0], bit_data};
    assign pad_byte   = sr << (byte_w - fill);   // Partial bits to the top, zeros below

    assign load_full = bit_fire & (fill == fill_w'(byte_w - 1));
    assign load_pad  = flush_req & ~out_valid & ~bit_fire & (fill != '0);
    assign done_now  = flush_req & ~out_valid & ~bit_fire & (fill == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fill       <= '0;
            out_valid  <= 1'b0;
            flush_pend <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= done_now;
            if (out_valid && byte_ready)
                out_valid <= 1'b0;
            if (bit_fire)
                fill <= fill + 1'b1;   // Wraps to zero on the eighth bit
            if (load_full || load_pad)
                out_valid <= 1'b1;
            if (load_pad)
                fill <= '0;
            if (done_now)
                flush_pend <= 1'b0;
            else if (flush)
                flush_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bit_fire)
            sr <= shift_next;
        if (load_full)
            out_data <= shift_next;
        else if (load_pad)
            out_data <= pad_byte;
    end

    assign byte_out = '{valid: out_valid, data: out_data};

endmodule

/* hw/code_table.sv */
`timescale 1ns/1ns

module code_table import huff_pkg::*; (
    input  logic                   clk,
    input  table_wr_t              table_wr,
    input  logic                   rd_en,
    input  logic [code_addr_w-1:0] rd_addr,
    output logic [path_w-1:0]      rd_path
);

    // One path word per character
    logic [path_w-1:0] mem [0:(1 << code_addr_w)-1];

    always_ff @(posedge clk) begin
        if (table_wr.en)
            mem[table_wr.addr] <= table_wr.path;
    end

    // Data valid one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_path <= mem[rd_addr];
    end

endmodule

/* hw/huff_csr.sv */
`timescale 1ns/1ns

module huff_csr import huff_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  axil_req_t          axil_req,
    output axil_rsp_t          axil_rsp,
    output table_wr_t          table_wr,
    output logic               start,
    output logic [count_w-1:0] total_chars,
    input  logic               busy,
    input  logic               flush_done
);

    logic                   wr_acc;    // AW and W ready together for one cycle
    logic                   bvalid;
    logic                   rvalid;
    logic [axi_data_w-1:0]  rdata;
    logic                   done;
    logic                   tw_en;
    logic [code_addr_w-1:0] tw_addr;
    logic [path_w-1:0]      tw_path;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_table;

    assign wr_fire  = wr_acc & axil_req.awvalid & axil_req.wvalid;
    assign rd_fire  = axil_req.arvalid & ~rvalid;   // arready is high while idle
    assign wr_table = axil_req.awaddr[axi_addr_w-1:code_addr_w+2] ==
                      table_base[axi_addr_w-1:code_addr_w+2];

    // Write channel handshake
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_acc <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wr_acc <= axil_req.awvalid & axil_req.wvalid & ~wr_acc & ~bvalid;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (axil_req.bready)
                bvalid <= 1'b0;
        end
    end

    // Control, total and sticky done
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            total_chars <= '0;
            start       <= 1'b0;
            done        <= 1'b0;
            tw_en       <= 1'b0;
        end else begin
            start <= wr_fire & (axil_req.awaddr == reg_ctrl) & axil_req.wstrb[0] &
                     axil_req.wdata[0] & ~busy;   // Ignored while a message runs
            tw_en <= wr_fire & wr_table;
            if (wr_fire && axil_req.awaddr == reg_total) begin
                for (int i = 0; i < count_w / 8; i++) begin
                    if (axil_req.wstrb[i])
                        total_chars[8*i +: 8] <= axil_req.wdata[8*i +: 8];
                end
            end
            if (start)
                done <= 1'b0;
            else if (flush_done)
                done <= 1'b1;
        end
    end

    // Table entry captured with the write beat
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            tw_addr <= axil_req.awaddr[code_addr_w+1:2];
            tw_path <= axil_req.wdata;
        end
    end

    // Read channel
    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (axil_req.rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (axil_req.araddr)
                reg_status: rdata <= {{(axi_data_w-2){1'b0}}, done, busy};
                reg_total:  rdata <= total_chars;
                default:    rdata <= '0;   // Control and table range read as zero
            endcase
        end
    end

    assign axil_rsp = '{
        awready: wr_acc,
        wready:  wr_acc,
        bresp:   resp_okay,
        bvalid:  bvalid,
        arready: ~rvalid,
        rdata:   rdata,
        rresp:   resp_okay,
        rvalid:  rvalid
    };

    assign table_wr = '{en: tw_en, addr: tw_addr, path: tw_path};

endmodule

/* hw/huff_encoder_top.sv */
`timescale 1ns/1ns

module huff_encoder_top import huff_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  axil_req_t    axil_req,
    output axil_rsp_t    axil_rsp,
    input  byte_stream_t char_in,
    output logic         char_ready,
    output byte_stream_t byte_out,
    input  logic         byte_ready
);

    table_wr_t              table_wr;
    logic                   start;
    logic [count_w-1:0]     total_chars;
    logic                   busy;
    logic                   flush_done;
    logic                   rd_en;
    logic [code_addr_w-1:0] rd_addr;
    logic [path_w-1:0]      rd_path;
    logic                   bit_valid;
    logic                   bit_data;
    logic                   bit_ready;
    logic                   flush;

    huff_csr csr_i (
        .clk         (clk),
        .rst         (rst),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .table_wr    (table_wr),
        .start       (start),
        .total_chars (total_chars),
        .busy        (busy),
        .flush_done  (flush_done)
    );

    code_table table_i (
        .clk      (clk),
        .table_wr (table_wr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_path  (rd_path)
    );

    huff_translate translate_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .total_chars (total_chars),
        .char_in     (char_in),
        .char_ready  (char_ready),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_path     (rd_path),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .bit_ready   (bit_ready),
        .flush       (flush),
        .busy        (busy)
    );

    bit_packer packer_i (
        .clk        (clk),
        .rst        (rst),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .bit_ready  (bit_ready),
        .flush      (flush),
        .flush_done (flush_done),
        .byte_out   (byte_out),
        .byte_ready (byte_ready)
    );

endmodule

/* hw/huff_pkg.sv */
package huff_pkg;

    // Code path and count widths
    localparam int path_w      = 32;
    localparam int code_addr_w = 8;
    localparam int count_w     = 32;
    localparam int idx_w       = $clog2(path_w);   // Bit index into a path or count word

    localparam int byte_w = 8;
    localparam int fill_w = $clog2(byte_w);

    localparam int axi_addr_w = 32;
    localparam int axi_data_w = 32;

    localparam logic [byte_w-1:0] eof_char = 8'h1A;   // Ends the text, never encoded

    // Register map
    localparam logic [axi_addr_w-1:0] reg_ctrl   = 32'h0000_0000;   // Bit 0 start pulse
    localparam logic [axi_addr_w-1:0] reg_status = 32'h0000_0004;   // Bit 0 busy, bit 1 done
    localparam logic [axi_addr_w-1:0] reg_total  = 32'h0000_0008;
    localparam logic [axi_addr_w-1:0] table_base = 32'h0000_0400;   // Entry at base + 4 * char

    localparam logic [1:0] resp_okay = 2'b00;

    // Master side of the register port
    typedef struct packed {
        logic [axi_addr_w-1:0]   awaddr;
        logic                    awvalid;
        logic [axi_data_w-1:0]   wdata;
        logic [axi_data_w/8-1:0] wstrb;
        logic                    wvalid;
        logic                    bready;
        logic [axi_addr_w-1:0]   araddr;
        logic                    arvalid;
        logic                    rready;
    } axil_req_t;

    // Slave side of the register port
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
        logic                  arready;
        logic [axi_data_w-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [code_addr_w-1:0] addr;
        logic [path_w-1:0]      path;
    } table_wr_t;

    // Ready travels separately, in the opposite direction
    typedef struct packed {
        logic              valid;
        logic [byte_w-1:0] data;
    } byte_stream_t;

endpackage

/* hw/huff_translate.sv */
`timescale 1ns/1ns

module huff_translate import huff_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [count_w-1:0]     total_chars,
    input  byte_stream_t           char_in,
    output logic                   char_ready,
    output logic                   rd_en,
    output logic [code_addr_w-1:0] rd_addr,
    input  logic [path_w-1:0]      rd_path,
    output logic                   bit_valid,
    output logic                   bit_data,
    input  logic                   bit_ready,
    output logic                   flush,
    output logic                   busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_count,       // Count word, MSB first
        st_wait_char,
        st_lookup,      // Table read in flight
        st_search,      // Skip down to the sentinel
        st_emit,
        st_finish
    } state_t;

    state_t            state;
    logic [idx_w-1:0]  idx;      // Down-counting bit index
    logic [path_w-1:0] path_q;
    logic              char_fire;
    logic              is_eof;

    assign is_eof     = char_in.data == eof_char;
    assign char_ready = state == st_wait_char;
    assign char_fire  = char_ready & char_in.valid;

    // Lookup strobe issued with the accept, none for the end character
    assign rd_en   = char_fire & ~is_eof;
    assign rd_addr = char_in.data;

    assign bit_valid = (state == st_count) || (state == st_emit);
    assign bit_data  = (state == st_count) ? total_chars[idx] : path_q[idx];
    assign flush     = state == st_finish;
    assign busy      = state != st_idle;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_count;
                        idx   <= idx_w'(count_w - 1);
                    end
                end
                st_count: begin
                    if (bit_ready) begin
                        idx <= idx - 1'b1;
                        if (idx == '0)
                            state <= st_wait_char;
                    end
                end
                st_wait_char: begin
                    if (char_fire)
                        state <= is_eof ? st_finish : st_lookup;
                end
                st_lookup: begin
                    state <= st_search;
                    idx   <= idx_w'(path_w - 1);
                end
                st_search: begin
                    // Sentinel in bit 0 means a zero-length code
                    if (idx == '0)
                        state <= st_wait_char;
                    else if (path_q[idx])
                        state <= st_emit;
                    idx <= idx - 1'b1;
                end
                st_emit: begin
                    if (bit_ready) begin
                        idx <= idx - 1'b1;
                        if (idx == '0)
                            state <= st_wait_char;
                    end
                end
                st_finish: state <= st_idle;   // Flush high for this one cycle
                default:   state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup)
            path_q <= rd_path;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the Huffman encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module huff_tb -Mdir obj_dir -o huff_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/huff_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* sim.f */
hw/huff_pkg.sv
hw/huff_csr.sv
hw/code_table.sv
hw/huff_translate.sv
hw/bit_packer.sv
hw/huff_encoder_top.sv
tests/huff_tb.sv

/* tests/huff_tb.sv */
`timescale 1ns/1ns

module huff_tb import huff_pkg::*; ();

    localparam int wait_limit = 4000;   // Cycles per wait loop
    localparam int n_alpha    = 8;

    logic         clk;
    logic         rst;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    byte_stream_t char_in;
    logic         char_ready;
    byte_stream_t byte_out;
    logic         byte_ready = 1'b0;

    logic [31:0]   lfsr = 32'h942097b2;
    logic [7:0]    alpha [0:n_alpha-1];
    bit            used [0:255];
    int            code_len [0:255];   // Reference code table
    logic [31:0]   code_bits [0:255];
    logic [7:0]    text [$];
    logic [7:0]    exp_bytes [$];
    logic [1023:0] ready_pat;
    logic [9:0]    pat_idx   = '0;
    logic          stall_on  = 1'b0;
    logic          hold_chk  = 1'b0;
    logic [7:0]    held_data = '0;

    huff_encoder_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .char_in    (char_in),
        .char_ready (char_ready),
        .byte_out   (byte_out),
        .byte_ready (byte_ready)
    );

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        int cnt;
        @(negedge clk);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.wvalid  = 1'b1;
        cnt = 0;
        while (!axil_rsp.awready) begin
            @(negedge clk);
            cnt++;
            assert (cnt < wait_limit) else report_failure("write beats were never accepted");
        end
        check_eq("wready", 32'(axil_rsp.wready), 32'h1);   // W beat taken together with AW
        @(negedge clk);   // Beats taken on the last rising edge
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        cnt = 0;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
            cnt++;
            assert (cnt < wait_limit) else report_failure("no write response arrived");
        end
        check_eq("bresp", 32'(axil_rsp.bresp), 32'(resp_okay));
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        int cnt;
        @(negedge clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        cnt = 0;
        while (!axil_rsp.arready) begin
            @(negedge clk);
            cnt++;
            assert (cnt < wait_limit) else report_failure("read address was never accepted");
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        cnt = 0;
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
            cnt++;
            assert (cnt < wait_limit) else report_failure("no read data arrived");
        end
        data = axil_rsp.rdata;
        check_eq("rresp", 32'(axil_rsp.rresp), 32'(resp_okay));
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic send_char(input logic [7:0] ch);
        int cnt;
        @(negedge clk);
        char_in.valid = 1'b1;
        char_in.data  = ch;
        cnt = 0;
        while (!char_ready) begin
            @(negedge clk);
            cnt++;
            assert (cnt < wait_limit)
            else report_failure($sformatf("character 0x%0h was never accepted", ch));
        end
        @(negedge clk);
        char_in.valid = 1'b0;
    endtask

    // New random code for one character, in the model and in the DUT table
    task automatic set_code(input logic [7:0] ch, input int len);
        code_len[ch]  = len;
        code_bits[ch] = rand_bits(len);
        axil_write(table_base + {22'd0, ch, 2'b00}, (32'd1 << len) | code_bits[ch]);
    endtask

    // Count word, code bits, zero pad to a whole byte
    task automatic make_expected(input logic [31:0] total);
        bit         bits_q [$];
        logic [7:0] b;
        logic [7:0] ch;
        b = '0;
        exp_bytes.delete();
        for (int i = 31; i >= 0; i--)
            bits_q.push_back(total[i]);
        foreach (text[k]) begin
            ch = text[k];
            for (int i = code_len[ch] - 1; i >= 0; i--)
                bits_q.push_back(code_bits[ch][i]);
        end
        while (bits_q.size() % 8 != 0)
            bits_q.push_back(1'b0);
        while (bits_q.size() > 0) begin
            for (int i = 0; i < 8; i++)
                b = {b[6:0], bits_q.pop_front()};
            exp_bytes.push_back(b);
        end
    endtask

    task automatic run_message(input int n_chars);
        logic [31:0] rd;
        logic [31:0] total;
        int          k;
        int          polls;
        text.delete();
        text.push_back(alpha[1]);   // Longest code, then the empty one
        text.push_back(alpha[0]);
        text.push_back(alpha[2]);
        while (text.size() < n_chars) begin
            k = int'(rand_bits(3));
            text.push_back(alpha[k]);
        end
        total = 32'(text.size());
        make_expected(total);
        axil_write(reg_total, total);
        axil_read(reg_total, rd);
        check_eq("reg_total", rd, total);
        axil_write(reg_ctrl, 32'h1);
        axil_read(reg_status, rd);
        check_eq("reg_status", rd, 32'h1);   // Busy, done cleared by start
        foreach (text[i])
            send_char(text[i]);
        send_char(eof_char);
        check_eq("char_ready", 32'(char_ready), 32'h0);
        polls = 0;
        rd    = '0;
        while (!rd[1]) begin
            axil_read(reg_status, rd);
            check_eq("char_ready", 32'(char_ready), 32'h0);
            polls++;
            assert (polls < 200) else report_failure("done never set after the end character");
        end
        check_eq("reg_status", rd, 32'h2);
        assert (exp_bytes.size() == 0)
        else report_failure("run finished before all expected bytes came out");
    endtask

    // Output sink with optional random stalls
    always @(negedge clk) begin : byte_sink
        logic       rdy;
        logic [7:0] exp;
        if (hold_chk) begin
            check_eq("byte_out.valid", 32'(byte_out.valid), 32'h1);
            check_eq("byte_out.data", 32'(byte_out.data), 32'(held_data));
        end
        rdy        = stall_on ? ready_pat[pat_idx] : 1'b1;
        pat_idx    = pat_idx + 10'd1;
        byte_ready = rdy;
        if (byte_out.valid && rdy) begin
            assert (exp_bytes.size() > 0)
            else report_failure("output byte arrived past the end of the expected stream");
            exp = exp_bytes.pop_front();
            check_eq("byte_out.data", 32'(byte_out.data), 32'(exp));
        end
        hold_chk  = byte_out.valid && !rdy;
        held_data = byte_out.data;
    end

    initial begin
        logic [7:0]  ch;
        logic [31:0] rd;
        clk      = 1'b0;
        rst      = 1'b1;
        axil_req = '0;
        char_in  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_eq("byte_out.valid", 32'(byte_out.valid), 32'h0);
        check_eq("char_ready", 32'(char_ready), 32'h0);
        axil_read(reg_status, rd);
        check_eq("reg_status", rd, 32'h0);

        for (int i = 0; i < n_alpha; i++) begin
            do
                ch = 8'(rand_bits(8));
            while (ch == eof_char || used[ch]);
            used[ch] = 1'b1;
            alpha[i] = ch;
            set_code(ch, i == 0 ? 0 : (i == 1 ? 12 : int'(rand_bits(4) % 13)));
        end
        run_message(40);

        // Second message under stalls, one entry rewritten
        for (int i = 0; i < 1024; i++)
            ready_pat[i] = lfsr_bit();
        stall_on = 1'b1;
        set_code(alpha[2], (code_len[alpha[2]] + 5) % 13);
        run_message(30);

        $display("Test OK");
        $finish;
    end

endmodule
